//--- Makefile
TOP := cfi_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir

//--- dv/cfi_tb.sv
`timescale 1ns/100ps

module cfi_tb;

   localparam int          stack_depth = 4;
   localparam int          n_commits   = 4000;
   localparam int          wait_limit  = 50;
   localparam logic [31:0] seed        = 32'h3c26_47cf;

   logic                          clk, rst_n, commit_valid, commit_ex, csr_en;
   cfi_pkg::op_e                  commit_op;
   logic [cfi_pkg::reg_w-1:0]     commit_rd, commit_rs1;
   logic [cfi_pkg::xlen-1:0]      commit_pc, ex_tval, exp_tval;
   logic [cfi_pkg::imm_w-1:0]     commit_imm;
   logic [cfi_pkg::nb_args_w-1:0] nb_args;
   logic                          ex_valid, rst_args, exp_valid, exp_rst_args;
   cfi_pkg::cause_e               ex_cause, exp_cause;

   // reference model state
   logic [31:0]              lcg_state;
   logic [cfi_pkg::xlen-1:0] model_stack [stack_depth];
   int                       model_count, n_faults;
   logic                     call_pending, ret_pending;

   clk_rst_gen u_clk_rst (.clk_o(clk), .rst_no(rst_n));

   cfi_monitor #(.stack_depth(stack_depth)) DUT (
      .clk_i (clk), .rst_ni (rst_n), .commit_valid_i (commit_valid),
      .commit_ex_i (commit_ex), .commit_op_i (commit_op), .commit_rd_i (commit_rd),
      .commit_rs1_i (commit_rs1), .commit_pc_i (commit_pc), .commit_imm_i (commit_imm),
      .csr_en_i (csr_en), .nb_args_i (nb_args), .ex_valid_o (ex_valid),
      .ex_cause_o (ex_cause), .ex_tval_o (ex_tval), .rst_args_o (rst_args)
   );

   ////////////////////////////////////////////////////////////////////////////
   // random numbers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // the low bits of an lcg repeat quickly so values come from the upper half
   task automatic draw_below(input int n, output int v);
      lcg_state = lcg_step(lcg_state);
      v = int'(lcg_state[31:16]) % n;
   endtask

   task automatic draw_pc(output logic [cfi_pkg::xlen-1:0] pc);
      int hi, lo;
      draw_below(65536, hi);
      draw_below(16384, lo);
      pc = {hi[15:0], lo[13:0], 2'b00};
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic make_commit();
      int kind, v;
      logic [cfi_pkg::nb_args_w-1:0] count;
      commit_valid = 1'b1;
      commit_ex    = 1'b0;
      commit_op    = cfi_pkg::OP_OTHER;
      commit_rd    = 5'd7;
      commit_rs1   = 5'd8;
      commit_imm   = '0;
      draw_pc(commit_pc);
      draw_below(16, kind);
      draw_below(4, v);
      // right after a call or a return, steer most commits to the slot that decides it
      if (call_pending && kind >= 5 && kind <= 12) begin
         kind = (kind <= 10) ? 20 : 21;
      end else if (ret_pending && kind >= 5 && kind <= 12) begin
         kind = (kind <= 10) ? 22 : 23;
      end
      case (kind)
         0, 1: begin
            commit_valid = 1'b0;
         end
         2, 3: begin
            commit_op = v[0] ? cfi_pkg::OP_JALR : cfi_pkg::OP_JAL;
            commit_rd = cfi_pkg::ra_reg;
         end
         4: begin
            // looks like a call but trapped, so nothing may see it
            commit_ex = 1'b1;
            commit_op = cfi_pkg::OP_JALR;
            commit_rd = cfi_pkg::ra_reg;
         end
         5, 6, 20, 21: begin
            if (kind == 6 || kind == 21) begin
               // the count misses the csr value by one or two and lies below it when variadic
               if (v[0]) begin
                  count = nb_args - 9'd1 - 9'(v[1]);
               end else begin
                  count = nb_args + 9'd1 + 9'(v[1]);
               end
               commit_imm = {v[0], count, cfi_pkg::marker_tag};
            end else begin
               count = nb_args + (v[0] ? 9'(v[1]) : 9'd0);
               commit_imm = {v[0], count, cfi_pkg::marker_tag};
            end
            commit_op  = cfi_pkg::OP_ADDI;
            commit_rd  = '0;
            commit_rs1 = '0;
         end
         7, 8: begin
            commit_op  = cfi_pkg::OP_JALR;
            commit_rd  = '0;
            commit_rs1 = cfi_pkg::ra_reg;
         end
         9, 22: begin
            if (model_count > 0) begin
               commit_pc = model_stack[model_count - 1];
            end
            // now and then the landing instruction is itself a call
            if (v == 0) begin
               commit_op = cfi_pkg::OP_JAL;
               commit_rd = cfi_pkg::ra_reg;
            end
         end
         default: begin
            // plain jumps and untagged nops that must not count as calls or markers
            if (v == 1) begin
               commit_op  = cfi_pkg::OP_ADDI;
               commit_rd  = '0;
               commit_rs1 = '0;
               commit_imm = 12'h001;
            end else if (v >= 2) begin
               commit_op = (v == 2) ? cfi_pkg::OP_JAL : cfi_pkg::OP_JALR;
               commit_rd = '0;
            end
         end
      endcase
      draw_below(8, v);
      csr_en = (v != 0);
      draw_below(8, v);
      if (v == 0) begin
         nb_args = cfi_pkg::nb_args_unknown;
      end else if (v == 1) begin
         draw_below(8, v);
         nb_args = 9'(v);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic args_pass(input logic [cfi_pkg::imm_w-1:0] imm,
                                      input logic [cfi_pkg::nb_args_w-1:0] nb);
      logic [cfi_pkg::nb_args_w-1:0] count;
      count = imm[cfi_pkg::marker_count_lsb +: cfi_pkg::nb_args_w];
      if (nb == cfi_pkg::nb_args_unknown) begin
         return 1'b1;
      end else if (imm[cfi_pkg::variadic_bit]) begin
         return count >= nb;
      end
      return count == nb;
   endfunction

   // updates the model with the commit being driven and predicts the next outputs
   task automatic predict();
      logic live, is_call, is_ret, is_marker, call_fault, ret_fault, ovf_fault;
      live       = commit_valid && !commit_ex;
      is_call    = live && commit_rd == cfi_pkg::ra_reg &&
                   (commit_op == cfi_pkg::OP_JAL || commit_op == cfi_pkg::OP_JALR);
      is_ret     = live && commit_op == cfi_pkg::OP_JALR && commit_rd == '0 &&
                   commit_rs1 == cfi_pkg::ra_reg;
      is_marker  = live && commit_op == cfi_pkg::OP_ADDI && commit_rd == '0 &&
                   commit_rs1 == '0 && commit_imm[1:0] == cfi_pkg::marker_tag;
      call_fault = call_pending && live && !(is_marker && args_pass(commit_imm, nb_args));
      ret_fault  = 1'b0;
      ovf_fault  = 1'b0;
      exp_rst_args = call_pending && live;
      if (ret_pending && live) begin
         if (model_count > 0 && commit_pc == model_stack[model_count - 1]) begin
            model_count--;
         end else begin
            ret_fault = 1'b1;
         end
      end
      if (is_call && model_count < stack_depth) begin
         model_stack[model_count] = commit_pc + 32'd4;
         model_count++;
      end else if (is_call) begin
         ovf_fault = 1'b1;
      end
      if (live) begin
         call_pending = is_call;
         ret_pending  = is_ret;
      end
      exp_valid = csr_en && (ret_fault || ovf_fault || call_fault);
      exp_cause = (ret_fault || ovf_fault) ? cfi_pkg::CAUSE_ILLEGAL_INSTR
                                           : cfi_pkg::CAUSE_BREAKPOINT;
      exp_tval  = (ret_fault || ovf_fault) ? commit_pc : '0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_now(input string why);
      $display("=== FAIL ===");
      $fatal(1, "%s", why);
   endtask

   task automatic check_exception(input logic got_valid, input cfi_pkg::cause_e got_cause,
                                  input logic want_valid, input cfi_pkg::cause_e want_cause);
      if (got_valid !== want_valid) begin
         $display("** Error at %0t: ex_valid_o is %b, expected %b",
                  $time, got_valid, want_valid);
         fail_now("exception valid mismatch");
      end else if (want_valid && got_cause !== want_cause) begin
         $display("** Error at %0t: ex_cause_o is %0d, expected %0d (%s)",
                  $time, got_cause, want_cause, want_cause.name());
         fail_now("exception cause mismatch");
      end
   endtask

   task automatic check_tval(input logic [cfi_pkg::xlen-1:0] got,
                             input logic [cfi_pkg::xlen-1:0] want);
      if (got !== want) begin
         $display("** Error at %0t: ex_tval_o is %h, expected %h", $time, got, want);
         fail_now("trap value mismatch");
      end
   endtask

   task automatic check_rst_args(input logic got, input logic want);
      if (got !== want) begin
         $display("** Error at %0t: rst_args_o is %b, expected %b", $time, got, want);
         fail_now("argument csr reset mismatch");
      end
   endtask

   initial begin
      int waited;
      commit_valid = 1'b0;
      commit_ex    = 1'b0;
      commit_op    = cfi_pkg::OP_OTHER;
      commit_rd    = '0;
      commit_rs1   = '0;
      commit_pc    = '0;
      commit_imm   = '0;
      csr_en       = 1'b1;
      nb_args      = 9'd3;
      lcg_state    = seed;
      model_count  = 0;
      n_faults     = 0;
      call_pending = 1'b0;
      ret_pending  = 1'b0;
      waited       = 0;
      while (rst_n !== 1'b1) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > wait_limit) begin
            fail_now("timeout: reset was never released");
         end
      end
      check_exception(ex_valid, ex_cause, 1'b0, cfi_pkg::CAUSE_ILLEGAL_INSTR);
      check_rst_args(rst_args, 1'b0);
      for (int i = 0; i < n_commits; i++) begin
         make_commit();
         predict();
         @(posedge clk);
         #1;
         check_exception(ex_valid, ex_cause, exp_valid, exp_cause);
         if (exp_valid) begin
            check_tval(ex_tval, exp_tval);
            n_faults++;
         end
         check_rst_args(rst_args, exp_rst_args);
      end
      commit_valid = 1'b0;
      waited = 0;
      while (ex_valid !== 1'b0 || rst_args !== 1'b0) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > wait_limit) begin
            fail_now("timeout: outputs did not settle after the last commit");
         end
      end
      $display("checked %0d commits, %0d exceptions", n_commits, n_faults);
      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- dv/clk_rst_gen.sv
`timescale 1ns/100ps

module clk_rst_gen #(
   parameter int period_ns  = 10,
   parameter int rst_cycles = 5
) (
   output logic clk_o,
   output logic rst_no
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(period_ns / 2) clk_o = ~clk_o;
      end
   end

   // released on a rising edge so the DUT sees rst_cycles whole cycles of reset
   initial begin
      rst_no = 1'b0;
      repeat (rst_cycles) @(posedge clk_o);
      rst_no <= 1'b1;
   end

endmodule

//--- logic/call_site_checker.sv
`timescale 1ns/100ps

module call_site_checker (
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  logic                          live_i,
   input  logic                          is_call_i,
   input  logic                          is_marker_i,
   input  logic [cfi_pkg::imm_w-1:0]     marker_imm_i,
   input  logic [cfi_pkg::nb_args_w-1:0] nb_args_i,
   output logic                          call_fault_o,
   output logic                          rst_args_o
);

   typedef enum logic {
      IDLE,
      WAIT_MARKER
   } state_e;

   state_e state_q, state_d;

   logic [cfi_pkg::nb_args_w-1:0] marker_count;
   logic                          variadic;
   logic                          args_ok;
   logic                          rst_args_d;

   assign marker_count = marker_imm_i[cfi_pkg::marker_count_lsb +: cfi_pkg::nb_args_w];
   assign variadic     = marker_imm_i[cfi_pkg::variadic_bit];

   // argument rule of the marker against the csr value
   always_comb begin
      if (nb_args_i == cfi_pkg::nb_args_unknown) begin
         args_ok = 1'b1;
      end else if (variadic) begin
         args_ok = (marker_count >= nb_args_i);
      end else begin
         args_ok = (marker_count == nb_args_i);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // forward-edge FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d      = state_q;
      call_fault_o = 1'b0;
      rst_args_d   = 1'b0;
      case (state_q)
         IDLE: begin
            if (is_call_i) begin
               state_d = WAIT_MARKER;
            end
         end
         WAIT_MARKER: begin
            // the first live commit after the call decides, whatever it is
            if (live_i) begin
               call_fault_o = !(is_marker_i && args_ok);
               rst_args_d   = 1'b1;
               // a call in the marker slot is itself a new pending call
               state_d      = is_call_i ? WAIT_MARKER : IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q    <= IDLE;
         rst_args_o <= 1'b0;
      end else begin
         state_q    <= state_d;
         rst_args_o <= rst_args_d;
      end
   end

   // the csr reset request only ever follows a resolved call
   a_rst_args_after_resolve : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      rst_args_o |-> $past(state_q == WAIT_MARKER && live_i)
   );

endmodule

//--- logic/cfi_monitor.sv
`timescale 1ns/100ps

module cfi_monitor #(
   parameter int stack_depth = 16
) (
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  logic                          commit_valid_i,
   input  logic                          commit_ex_i,
   input  cfi_pkg::op_e                  commit_op_i,
   input  logic [cfi_pkg::reg_w-1:0]     commit_rd_i,
   input  logic [cfi_pkg::reg_w-1:0]     commit_rs1_i,
   input  logic [cfi_pkg::xlen-1:0]      commit_pc_i,
   input  logic [cfi_pkg::imm_w-1:0]     commit_imm_i,
   input  logic                          csr_en_i,
   input  logic [cfi_pkg::nb_args_w-1:0] nb_args_i,
   output logic                          ex_valid_o,
   output cfi_pkg::cause_e               ex_cause_o,
   output logic [cfi_pkg::xlen-1:0]      ex_tval_o,
   output logic                          rst_args_o
);

   logic                     live, is_call, is_ret, is_marker;
   logic                     call_fault, ret_fault, overflow_fault;
   logic                     push, pop, full, empty;
   logic [cfi_pkg::xlen-1:0] push_data, top;

   commit_decoder u_decoder (
      .commit_valid_i (commit_valid_i), .commit_ex_i  (commit_ex_i),
      .commit_op_i    (commit_op_i),    .commit_rd_i  (commit_rd_i),
      .commit_rs1_i   (commit_rs1_i),   .commit_imm_i (commit_imm_i),
      .live_o         (live),           .is_call_o    (is_call),
      .is_ret_o       (is_ret),         .is_marker_o  (is_marker)
   );

   call_site_checker u_call_chk (
      .clk_i        (clk_i),      .rst_ni       (rst_ni),
      .live_i       (live),       .is_call_i    (is_call),
      .is_marker_i  (is_marker),  .marker_imm_i (commit_imm_i),
      .nb_args_i    (nb_args_i),  .call_fault_o (call_fault),
      .rst_args_o   (rst_args_o)
   );

   return_checker u_ret_chk (
      .clk_i       (clk_i),       .rst_ni      (rst_ni),
      .live_i      (live),        .is_call_i   (is_call),
      .is_ret_i    (is_ret),      .commit_pc_i (commit_pc_i),
      .top_i       (top),         .full_i      (full),
      .empty_i     (empty),       .push_o      (push),
      .push_data_o (push_data),   .pop_o       (pop),
      .ret_fault_o (ret_fault),   .overflow_fault_o (overflow_fault)
   );

   shadow_stack #(.stack_depth(stack_depth)) u_stack (
      .clk_i  (clk_i), .rst_ni  (rst_ni), .push_i  (push), .push_data_i (push_data),
      .pop_i  (pop),   .top_o   (top),    .full_o  (full), .empty_o     (empty)
   );

   fault_report u_fault (
      .clk_i       (clk_i),     .rst_ni           (rst_ni),
      .csr_en_i    (csr_en_i),  .ret_fault_i      (ret_fault),
      .call_fault_i (call_fault), .overflow_fault_i (overflow_fault),
      .commit_pc_i (commit_pc_i), .ex_valid_o     (ex_valid_o),
      .ex_cause_o  (ex_cause_o),  .ex_tval_o      (ex_tval_o)
   );

endmodule

//--- logic/cfi_pkg.sv
package cfi_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int xlen      = 32;
   localparam int reg_w     = 5;
   localparam int nb_args_w = 9;
   localparam int imm_w     = 12;

   // x1 holds the return address in the standard calling convention
   localparam logic [reg_w-1:0] ra_reg = 5'd1;

   ////////////////////////////////////////////////////////////////////////////
   // marker no-op encoding: addi x0, x0, imm
   ////////////////////////////////////////////////////////////////////////////

   // imm[1:0] carries the tag, imm[10:2] the argument count, imm[11] variadic
   localparam logic [1:0] marker_tag       = 2'd2;
   localparam int         marker_count_lsb = 2;
   localparam int         variadic_bit     = 11;

   // an all-ones csr means software has not set a count for this call
   localparam logic [nb_args_w-1:0] nb_args_unknown = '1;

   typedef enum logic [1:0] {
      OP_OTHER,
      OP_JAL,
      OP_JALR,
      OP_ADDI
   } op_e;

   // values follow the risc-v mcause encoding
   typedef enum logic [3:0] {
      CAUSE_ILLEGAL_INSTR = 4'd2,
      CAUSE_BREAKPOINT    = 4'd3
   } cause_e;

endpackage

//--- logic/commit_decoder.sv
`timescale 1ns/100ps

module commit_decoder (
   input  logic                        commit_valid_i,
   input  logic                        commit_ex_i,
   input  cfi_pkg::op_e                commit_op_i,
   input  logic [cfi_pkg::reg_w-1:0]   commit_rd_i,
   input  logic [cfi_pkg::reg_w-1:0]   commit_rs1_i,
   input  logic [cfi_pkg::imm_w-1:0]   commit_imm_i,
   output logic                        live_o,
   output logic                        is_call_o,
   output logic                        is_ret_o,
   output logic                        is_marker_o
);

   logic call_shape;
   logic ret_shape;
   logic marker_shape;

   // a trapped commit never retired, so it counts as nothing at all
   assign live_o = commit_valid_i && !commit_ex_i;

   // jal or jalr that links into ra
   assign call_shape = ((commit_op_i == cfi_pkg::OP_JAL) ||
                        (commit_op_i == cfi_pkg::OP_JALR)) &&
                       (commit_rd_i == cfi_pkg::ra_reg);

   // jalr x0, 0(ra) is the canonical ret
   assign ret_shape = (commit_op_i == cfi_pkg::OP_JALR) &&
                      (commit_rd_i == '0) &&
                      (commit_rs1_i == cfi_pkg::ra_reg);

   // addi x0, x0, imm with the tag in the two low bits
   assign marker_shape = (commit_op_i == cfi_pkg::OP_ADDI) &&
                         (commit_rd_i == '0) &&
                         (commit_rs1_i == '0) &&
                         (commit_imm_i[1:0] == cfi_pkg::marker_tag);

   assign is_call_o   = live_o && call_shape;
   assign is_ret_o    = live_o && ret_shape;
   assign is_marker_o = live_o && marker_shape;

endmodule

//--- logic/fault_report.sv
`timescale 1ns/100ps

module fault_report (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     csr_en_i,
   input  logic                     ret_fault_i,
   input  logic                     overflow_fault_i,
   input  logic                     call_fault_i,
   input  logic [cfi_pkg::xlen-1:0] commit_pc_i,
   output logic                     ex_valid_o,
   output cfi_pkg::cause_e          ex_cause_o,
   output logic [cfi_pkg::xlen-1:0] ex_tval_o
);

   logic                     ex_valid_d;
   cfi_pkg::cause_e          ex_cause_d;
   logic [cfi_pkg::xlen-1:0] ex_tval_d;

   ////////////////////////////////////////////////////////////////////////////
   // priority select
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      ex_valid_d = 1'b0;
      ex_cause_d = cfi_pkg::CAUSE_ILLEGAL_INSTR;
      ex_tval_d  = '0;
      if (csr_en_i) begin
         if (ret_fault_i || overflow_fault_i) begin
            // tval is the landing address of a bad return or the pc of a call
            // that found the stack full
            ex_valid_d = 1'b1;
            ex_cause_d = cfi_pkg::CAUSE_ILLEGAL_INSTR;
            ex_tval_d  = commit_pc_i;
         end else if (call_fault_i) begin
            ex_valid_d = 1'b1;
            ex_cause_d = cfi_pkg::CAUSE_BREAKPOINT;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ex_valid_o <= 1'b0;
      end else begin
         ex_valid_o <= ex_valid_d;
      end
   end

   always_ff @(posedge clk_i) begin
      ex_cause_o <= ex_cause_d;
      ex_tval_o  <= ex_tval_d;
   end

endmodule

//--- logic/return_checker.sv
`timescale 1ns/100ps

module return_checker (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     live_i,
   input  logic                     is_call_i,
   input  logic                     is_ret_i,
   input  logic [cfi_pkg::xlen-1:0] commit_pc_i,
   input  logic [cfi_pkg::xlen-1:0] top_i,
   input  logic                     full_i,
   input  logic                     empty_i,
   output logic                     push_o,
   output logic [cfi_pkg::xlen-1:0] push_data_o,
   output logic                     pop_o,
   output logic                     ret_fault_o,
   output logic                     overflow_fault_o
);

   // call and jalr are 4-byte instructions since compressed encodings are not handled
   localparam logic [cfi_pkg::xlen-1:0] ret_offset = 4;

   typedef enum logic {
      IDLE,
      WAIT_TARGET
   } state_e;

   state_e state_q, state_d;

   logic target_ok;

   assign target_ok = !empty_i && (commit_pc_i == top_i);

   ////////////////////////////////////////////////////////////////////////////
   // return FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d     = state_q;
      pop_o       = 1'b0;
      ret_fault_o = 1'b0;
      case (state_q)
         IDLE: begin
            if (is_ret_i) begin
               state_d = WAIT_TARGET;
            end
         end
         WAIT_TARGET: begin
            // the next live commit is where the return actually landed
            if (live_i) begin
               pop_o       = target_ok;
               ret_fault_o = !target_ok;
               // a ret landing on another ret keeps us waiting for its target
               state_d     = is_ret_i ? WAIT_TARGET : IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // a pop in the same cycle frees a slot, so a full stack only overflows
   // when nothing leaves it
   assign push_o           = is_call_i && (!full_i || pop_o);
   assign overflow_fault_o = is_call_i && full_i && !pop_o;
   assign push_data_o      = commit_pc_i + ret_offset;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   a_no_pop_when_empty : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      pop_o |-> !empty_i
   );

endmodule

//--- logic/shadow_stack.sv
`timescale 1ns/100ps

module shadow_stack #(
   parameter int stack_depth = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     push_i,
   input  logic [cfi_pkg::xlen-1:0] push_data_i,
   input  logic                     pop_i,
   output logic [cfi_pkg::xlen-1:0] top_o,
   output logic                     full_o,
   output logic                     empty_o
);

   // the pointer counts entries, so it needs one more code than an index
   localparam int ptr_w = $clog2(stack_depth + 1);
   localparam int idx_w = $clog2(stack_depth);

   logic [cfi_pkg::xlen-1:0] mem_q [stack_depth];
   logic [ptr_w-1:0]         ptr_q;
   logic [idx_w-1:0]         top_idx;
   logic [idx_w-1:0]         free_idx;
   logic                     do_replace;
   logic                     do_push;
   logic                     do_pop;

   assign empty_o = (ptr_q == '0);
   assign full_o  = (ptr_q == ptr_w'(stack_depth));

   assign top_idx  = idx_w'(ptr_q - 1'b1);
   assign free_idx = idx_w'(ptr_q);

   // push and pop together overwrite the top in place
   assign do_replace = push_i && pop_i && !empty_o;
   assign do_push    = push_i && !pop_i && !full_o;
   assign do_pop     = pop_i && !push_i && !empty_o;

   assign top_o = empty_o ? '0 : mem_q[top_idx];

   always_ff @(posedge clk_i) begin
      if (do_replace) begin
         mem_q[top_idx] <= push_data_i;
      end else if (do_push) begin
         mem_q[free_idx] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ptr_q <= '0;
      end else if (do_push) begin
         ptr_q <= ptr_q + 1'b1;
      end else if (do_pop) begin
         ptr_q <= ptr_q - 1'b1;
      end
   end

   a_ptr_in_range : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ptr_q <= ptr_w'(stack_depth)
   );

endmodule

//--- tb.f
logic/cfi_pkg.sv
logic/commit_decoder.sv
logic/call_site_checker.sv
logic/return_checker.sv
logic/shadow_stack.sv
logic/fault_report.sv
logic/cfi_monitor.sv
dv/clk_rst_gen.sv
dv/cfi_tb.sv
